// ==== board_top.f ====
board_pkg.sv
uart_rx.sv
uart_loader.sv
cmd_ram.sv
cmd_engine.sv
seg7_scan.sv
keypad_decode.sv
board_top.sv
board_top_tb.sv

// ==== Makefile ====
SRCS := $(filter-out +%,$(shell cat board_top.f))

.PHONY: all run clean

all: run

obj_dir/board_top_sim: $(SRCS) board_top.f
	verilator --binary --assert --top-module board_top_tb -f board_top.f -o board_top_sim

run: obj_dir/board_top_sim
	./obj_dir/board_top_sim | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== board_top_tb.sv ====
`timescale 1ns/1ps

module board_top_tb;

    localparam int clks_per_bit = 8;
    localparam int scan_div = 16;
    localparam int debounce = 4;
    localparam int ram_aw = 6;
    // ten loads of at most 41 bytes at 80 cycles per byte, plus scan windows, with margin
    localparam int max_cycles = 60000;

    logic                               clk;
    logic                               rst_n;
    logic                               rx;
    logic [15:0]                        kp;
    logic [board_pkg::led_w-1:0]        led_out;
    logic [board_pkg::seg_digits-1:0]   seg_en;
    logic [6:0]                         seg_out;
    logic                               halted;

    logic [31:0] prog [0:63];
    int          prog_len;
    logic [31:0] rng_state;
    logic [15:0] exp_seg;
    logic        seg_check_on;
    logic [3:0]  seg_seen;
    int          errors = 0;
    int          checks = 0;
    int          seg_errors = 0;
    int          seg_checks = 0;
    int          tests = 0;
    int          cycles = 0;

    board_top #(
        .CLKS_PER_BIT(clks_per_bit),
        .SCAN_DIV(scan_div),
        .DEBOUNCE(debounce),
        .RAM_AW(ram_aw)
    ) board_top_i (
        .clk(clk),
        .rst_n(rst_n),
        .rx(rx),
        .kp(kp),
        .led_out(led_out),
        .seg_en(seg_en),
        .seg_out(seg_out),
        .halted(halted)
    );

    always #10 clk = ~clk;

    // lit segments in gfedcba order, inverted for the active-low pins
    function automatic logic [6:0] seg_pattern(input logic [3:0] h);
        logic [6:0] lit;
        case (h)
            4'h0: lit = 7'b0111111;
            4'h1: lit = 7'b0000110;
            4'h2: lit = 7'b1011011;
            4'h3: lit = 7'b1001111;
            4'h4: lit = 7'b1100110;
            4'h5: lit = 7'b1101101;
            4'h6: lit = 7'b1111101;
            4'h7: lit = 7'b0000111;
            4'h8: lit = 7'b1111111;
            4'h9: lit = 7'b1101111;
            4'ha: lit = 7'b1110111;
            4'hb: lit = 7'b1111100;
            4'hc: lit = 7'b0111001;
            4'hd: lit = 7'b1011110;
            4'he: lit = 7'b1111001;
            default: lit = 7'b1110001;
        endcase
        return ~lit;
    endfunction

    function automatic logic [31:0] make_word(input board_pkg::cmd_op_e op,
                                              input logic [27:0] operand);
        return {op, operand};
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // walks the program the way the command set defines it
    function automatic void ref_model(input logic [3:0] key, output logic [15:0] led,
                                      output logic [15:0] seg, output logic halt);
        int          pc;
        int          steps;
        logic [31:0] w;
        led = '0;
        seg = '0;
        halt = 1'b0;
        pc = 0;
        steps = 0;
        while (!halt && steps < 256) begin
            steps++;
            if (pc >= prog_len) begin
                halt = 1'b1;
            end else begin
                w = prog[pc];
                pc++;
                case (board_pkg::cmd_op_e'(w[31:28]))
                    board_pkg::op_led: led = w[15:0];
                    board_pkg::op_seg: seg = w[15:0];
                    board_pkg::op_keyled: led = 16'(key);
                    board_pkg::op_jump: pc = int'(w[27:0]);
                    board_pkg::op_halt: halt = 1'b1;
                    default: ;
                endcase
            end
        end
    endfunction

    task automatic drive_bit(input logic v);
        @(posedge clk);
        #2;
        rx = v;
        repeat (clks_per_bit - 1) @(posedge clk);
    endtask

    // 8N1, lsb first
    task automatic send_byte(input logic [7:0] b);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(b[i]);
        end
        drive_bit(1'b1);
    endtask

    task automatic load_program();
        send_byte(8'(prog_len));
        for (int i = 0; i < prog_len; i++) begin
            for (int b = 0; b < 4; b++) begin
                send_byte(prog[i][8*b +: 8]);
            end
        end
    endtask

    task automatic hold_reset();
        @(posedge clk);
        #2;
        rst_n = 1'b0;
        repeat (9) @(posedge clk);
    endtask

    task automatic release_reset();
        @(posedge clk);
        #2;
        rst_n = 1'b1;
    endtask

    task automatic apply_reset();
        hold_reset();
        release_reset();
    endtask

    task automatic press_key(input int idx, input int hold);
        @(posedge clk);
        #2;
        kp = 16'd1 << idx;
        repeat (hold) @(posedge clk);
        #2;
        kp = '0;
    endtask

    task automatic wait_halt(input int limit);
        int n;
        n = 0;
        while (!halted && n < limit) begin
            @(negedge clk);
            n++;
        end
        checks++;
        assert (halted) else begin
            $display("halted did not rise within %0d cycles at time %0t", limit, $time);
            errors++;
        end
    endtask

    task automatic wait_led(input logic [15:0] value, input int limit);
        int n;
        n = 0;
        while (led_out != value && n < limit) begin
            @(negedge clk);
            n++;
        end
        checks++;
        assert (led_out == value) else begin
            $display("led_out never reached %h within %0d cycles at time %0t",
                     value, limit, $time);
            errors++;
        end
    endtask

    task automatic check_result(input logic [3:0] key);
        logic [15:0] e_led;
        logic [15:0] e_seg;
        logic        e_halt;
        ref_model(key, e_led, e_seg, e_halt);
        @(negedge clk);
        checks += 2;
        assert (led_out == e_led) else begin
            $display("FAIL %0t: led_out is %h, expected %h", $time, led_out, e_led);
            errors++;
        end
        assert (halted == e_halt) else begin
            $display("FAIL %0t: halted is %b, expected %b", $time, halted, e_halt);
            errors++;
        end
        // let the scanner pass over every digit at least once
        @(posedge clk);
        #2;
        exp_seg = e_seg;
        seg_check_on = 1'b1;
        repeat (5 * scan_div) @(posedge clk);
        #2;
        checks++;
        assert (seg_seen == 4'hf) else begin
            $display("FAIL %0t: digits scanned %b, expected all four", $time, seg_seen);
            errors++;
        end
        seg_check_on = 1'b0;
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        if (errors + seg_errors == err_before) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors + seg_errors - err_before);
        end
    endtask

    // compares each active digit against the font
    always @(negedge clk) begin
        if (!seg_check_on) begin
            seg_seen = '0;
        end else begin
            seg_checks++;
            assert ($countones(~seg_en) == 1) else begin
                $display("FAIL %0t: seg_en %b is not a single active digit", $time, seg_en);
                seg_errors++;
            end
            for (int d = 0; d < 4; d++) begin
                if (!seg_en[d]) begin
                    seg_seen[d] = 1'b1;
                    seg_checks++;
                    assert (seg_out == seg_pattern(exp_seg[4*d +: 4])) else begin
                        $display("FAIL %0t: digit %0d shows %b, expected %b", $time, d,
                                 seg_out, seg_pattern(exp_seg[4*d +: 4]));
                        seg_errors++;
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        logic [31:0]        r;
        int                 n;
        int                 err_before;
        board_pkg::cmd_op_e op;
        clk = 1'b0;
        rst_n = 1'b0;
        rx = 1'b1;
        kp = '0;
        exp_seg = '0;
        seg_check_on = 1'b0;
        rng_state = 32'h83da_86d5;

        // led, display and halt
        err_before = errors + seg_errors;
        apply_reset();
        prog[0] = make_word(board_pkg::op_led, 28'h000a5c3);
        prog[1] = make_word(board_pkg::op_seg, 28'h0001234);
        prog[2] = make_word(board_pkg::op_halt, 28'h0);
        prog_len = 3;
        load_program();
        wait_halt(400);
        check_result(4'd0);
        end_test("led_seg_halt", err_before);

        // key 9 lands in the led register
        err_before = errors + seg_errors;
        apply_reset();
        prog[0] = make_word(board_pkg::op_keyled, 28'h0);
        prog[1] = make_word(board_pkg::op_halt, 28'h0);
        prog_len = 2;
        load_program();
        // engine reaches its key wait a few cycles after the last byte
        repeat (30) @(posedge clk);
        press_key(9, 10);
        wait_halt(400);
        check_result(4'd9);
        end_test("keyled", err_before);

        // jump over one led command
        err_before = errors + seg_errors;
        apply_reset();
        prog[0] = make_word(board_pkg::op_led, 28'h0000bee);
        prog[1] = make_word(board_pkg::op_jump, 28'h3);
        prog[2] = make_word(board_pkg::op_led, 28'h000dead);
        prog[3] = make_word(board_pkg::op_halt, 28'h0);
        // only reached if the jump lands one word late
        prog[4] = make_word(board_pkg::op_led, 28'h0000f00);
        prog_len = 5;
        load_program();
        wait_halt(400);
        check_result(4'd0);
        end_test("jump", err_before);

        // reset while the engine waits for a key, then reload
        err_before = errors + seg_errors;
        apply_reset();
        prog[0] = make_word(board_pkg::op_led, 28'h0001111);
        prog[1] = make_word(board_pkg::op_keyled, 28'h0);
        prog[2] = make_word(board_pkg::op_halt, 28'h0);
        prog_len = 3;
        load_program();
        wait_led(16'h1111, 400);
        hold_reset();
        @(negedge clk);
        checks += 3;
        assert (led_out == '0) else begin
            $display("FAIL %0t: led_out is %h in reset, expected 0", $time, led_out);
            errors++;
        end
        assert (halted == 1'b0) else begin
            $display("FAIL %0t: halted is %b in reset, expected 0", $time, halted);
            errors++;
        end
        assert (seg_en == 4'hf) else begin
            $display("FAIL %0t: seg_en is %b in reset, expected 1111", $time, seg_en);
            errors++;
        end
        release_reset();
        prog[0] = make_word(board_pkg::op_seg, 28'h000beef);
        prog[1] = make_word(board_pkg::op_led, 28'h0000f0f);
        prog[2] = make_word(board_pkg::op_halt, 28'h0);
        prog_len = 3;
        load_program();
        wait_halt(400);
        check_result(4'd0);
        end_test("mid_run_reset", err_before);

        // random led, seg and nop programs
        for (int t = 0; t < 5; t++) begin
            err_before = errors + seg_errors;
            apply_reset();
            r = next_rand();
            n = 2 + int'(r[18:16]);
            for (int i = 0; i < n; i++) begin
                r = next_rand();
                case (r[31:30])
                    2'd0: op = board_pkg::op_nop;
                    2'd1: op = board_pkg::op_led;
                    default: op = board_pkg::op_seg;
                endcase
                r = next_rand();
                prog[i] = make_word(op, r[27:0]);
            end
            prog[n] = make_word(board_pkg::op_halt, 28'h0);
            prog_len = n + 1;
            load_program();
            wait_halt(400);
            check_result(4'd0);
            end_test($sformatf("random_%0d", t), err_before);
        end

        $display("tests %0d, checks %0d, errors %0d", tests, checks + seg_checks,
                 errors + seg_errors);
        if (errors + seg_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== board_top.sv ====
`timescale 1ns/1ps

module board_top #(
    parameter int CLKS_PER_BIT = 868,
    parameter int SCAN_DIV     = 100000,
    parameter int DEBOUNCE     = 200000,
    parameter int RAM_AW       = 10
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               rx,
    input  logic [2**board_pkg::key_w-1:0]     kp,
    output logic [board_pkg::led_w-1:0]        led_out,
    output logic [board_pkg::seg_digits-1:0]   seg_en,
    output logic [6:0]                         seg_out,
    output logic                               halted
);

    logic [7:0]                         rx_byte;
    logic                               rx_valid;
    logic                               wr_en;
    logic [RAM_AW-1:0]                  wr_addr, rd_addr;
    logic [board_pkg::word_w-1:0]       wr_data, rd_data;
    logic                               load_done;
    logic [RAM_AW:0]                    word_count;
    logic                               key_valid;
    logic [board_pkg::key_w-1:0]        key_idx;
    logic [4*board_pkg::seg_digits-1:0] seg_value;

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_rx_inst (
        .clk,
        .rst_n,
        .rx,
        .rx_byte,
        .rx_valid
    );

    uart_loader #(.RAM_AW(RAM_AW)) uart_loader_inst (
        .clk,
        .rst_n,
        .rx_byte,
        .rx_valid,
        .wr_en,
        .wr_addr,
        .wr_data,
        .done(load_done),
        .word_count
    );

    cmd_ram #(.RAM_AW(RAM_AW)) cmd_ram_inst (
        .clk,
        .wr_en,
        .wr_addr,
        .wr_data,
        .rd_addr,
        .rd_data
    );

    // engine starts once the program is in memory
    cmd_engine #(.RAM_AW(RAM_AW)) cmd_engine_inst (
        .clk,
        .rst_n,
        .start(load_done),
        .word_count,
        .rd_data,
        .key_valid,
        .key_idx,
        .rd_addr,
        .led_out,
        .seg_value,
        .halted
    );

    seg7_scan #(.SCAN_DIV(SCAN_DIV)) seg7_scan_inst (
        .clk,
        .rst_n,
        .value(seg_value),
        .seg_en,
        .seg_out
    );

    keypad_decode #(.DEBOUNCE(DEBOUNCE)) keypad_decode_inst (
        .clk,
        .rst_n,
        .kp,
        .key_valid,
        .key_idx
    );

endmodule

// ==== keypad_decode.sv ====
`timescale 1ns/1ps

module keypad_decode #(
    parameter int DEBOUNCE = 200000
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [2**board_pkg::key_w-1:0] kp,
    output logic                           key_valid,
    output logic [board_pkg::key_w-1:0]    key_idx
);

    localparam int nkeys = 2 ** board_pkg::key_w;
    localparam int cnt_w = $clog2(DEBOUNCE + 1);

    logic [nkeys-1:0] kp_meta, kp_sync, kp_last;
    logic [cnt_w-1:0] stable_cnt;
    logic             stable;
    logic             armed;

    // lowest pressed key wins
    function automatic logic [board_pkg::key_w-1:0] lowest_key(input logic [nkeys-1:0] keys);
        lowest_key = '0;
        for (int i = nkeys - 1; i >= 0; i--) begin
            if (keys[i]) begin
                lowest_key = board_pkg::key_w'(i);
            end
        end
    endfunction

    assign stable = (stable_cnt == cnt_w'(DEBOUNCE));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            kp_meta    <= '0;
            kp_sync    <= '0;
            kp_last    <= '0;
            stable_cnt <= '0;
            armed      <= 1'b1;
            key_valid  <= 1'b0;
            key_idx    <= '0;
        end else begin
            kp_meta   <= kp;
            kp_sync   <= kp_meta;
            kp_last   <= kp_sync;
            key_valid <= 1'b0;
            if (kp_sync != kp_last) begin
                stable_cnt <= '0;
            end else if (!stable) begin
                stable_cnt <= stable_cnt + 1'b1;
            end
            // release re-arms, first settled press fires once
            if (stable && kp_last == '0) begin
                armed <= 1'b1;
            end else if (stable && armed) begin
                armed     <= 1'b0;
                key_valid <= 1'b1;
                key_idx   <= lowest_key(kp_last);
            end
        end
    end

endmodule

// ==== seg7_scan.sv ====
`timescale 1ns/1ps

module seg7_scan #(
    parameter int SCAN_DIV = 100000
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [4*board_pkg::seg_digits-1:0]   value,
    output logic [board_pkg::seg_digits-1:0]     seg_en,
    output logic [6:0]                           seg_out
);

    localparam int div_w = $clog2(SCAN_DIV + 1);

    logic [div_w-1:0]                div_cnt;
    logic [board_pkg::seg_digits-1:0] sel;
    logic [3:0]                      nibble;

    // gfedcba, lit segment is 0
    function automatic logic [6:0] hex_font(input logic [3:0] h);
        case (h)
            4'h0: hex_font = ~7'h3f;
            4'h1: hex_font = ~7'h06;
            4'h2: hex_font = ~7'h5b;
            4'h3: hex_font = ~7'h4f;
            4'h4: hex_font = ~7'h66;
            4'h5: hex_font = ~7'h6d;
            4'h6: hex_font = ~7'h7d;
            4'h7: hex_font = ~7'h07;
            4'h8: hex_font = ~7'h7f;
            4'h9: hex_font = ~7'h6f;
            4'ha: hex_font = ~7'h77;
            4'hb: hex_font = ~7'h7c;
            4'hc: hex_font = ~7'h39;
            4'hd: hex_font = ~7'h5e;
            4'he: hex_font = ~7'h79;
            default: hex_font = ~7'h71;
        endcase
    endfunction

    always_comb begin
        nibble = '0;
        for (int i = 0; i < board_pkg::seg_digits; i++) begin
            if (sel[i]) begin
                nibble = value[4*i +: 4];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt <= '0;
            sel     <= board_pkg::seg_digits'(1);
            seg_en  <= '1;
            seg_out <= '1;
        end else begin
            if (div_cnt == div_w'(SCAN_DIV - 1)) begin
                div_cnt <= '0;
                sel     <= {sel[board_pkg::seg_digits-2:0], sel[board_pkg::seg_digits-1]};
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            // enable and pattern move together
            seg_en  <= ~sel;
            seg_out <= hex_font(nibble);
        end
    end

endmodule

// ==== cmd_engine.sv ====
`timescale 1ns/1ps

module cmd_engine #(
    parameter int RAM_AW = 10
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  logic [RAM_AW:0]              word_count,
    input  logic [board_pkg::word_w-1:0] rd_data,
    input  logic                         key_valid,
    input  logic [board_pkg::key_w-1:0]  key_idx,
    output logic [RAM_AW-1:0]            rd_addr,
    output logic [board_pkg::led_w-1:0]  led_out,
    output logic [4*board_pkg::seg_digits-1:0] seg_value,
    output logic                         halted
);

    localparam int depth = 2 ** RAM_AW;
    localparam int opnd_w = board_pkg::word_w - board_pkg::op_w;

    typedef enum logic [2:0] {idle, fetch, exec, wait_key, halt} state_e;

    state_e              state;
    logic [RAM_AW:0]     pc;
    board_pkg::cmd_op_e  opcode;
    logic [opnd_w-1:0]   operand;

    // one spare pc bit so running off the end is visible
    assign rd_addr = pc[RAM_AW-1:0];

    assign opcode  = board_pkg::cmd_op_e'(rd_data[board_pkg::word_w-1 -: board_pkg::op_w]);
    assign operand = rd_data[opnd_w-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= idle;
            pc        <= '0;
            led_out   <= '0;
            seg_value <= '0;
            halted    <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    pc <= '0;
                    if (start) begin
                        state <= fetch;
                    end
                end
                // ram read is in flight this cycle
                fetch: begin
                    if (pc >= word_count) begin
                        state  <= halt;
                        halted <= 1'b1;
                    end else begin
                        state <= exec;
                    end
                end
                exec: begin
                    state <= fetch;
                    pc    <= pc + 1'b1;
                    case (opcode)
                        board_pkg::op_led: begin
                            led_out <= operand[board_pkg::led_w-1:0];
                        end
                        board_pkg::op_seg: begin
                            seg_value <= operand[4*board_pkg::seg_digits-1:0];
                        end
                        board_pkg::op_keyled: begin
                            state <= wait_key;
                            pc    <= pc;
                        end
                        board_pkg::op_jump: begin
                            pc <= operand[RAM_AW:0];
                        end
                        board_pkg::op_halt: begin
                            state  <= halt;
                            halted <= 1'b1;
                        end
                        // op_nop and unknown codes just advance
                        default: ;
                    endcase
                end
                wait_key: begin
                    if (key_valid) begin
                        led_out <= board_pkg::led_w'(key_idx);
                        pc      <= pc + 1'b1;
                        state   <= fetch;
                    end
                end
                halt: ;
                default: state <= idle;
            endcase
        end
    end

    a_halt_sticky: assert property (
        @(posedge clk) disable iff (!rst_n) halted |=> halted
    );

    // word_count from the loader must keep every executed address in memory
    a_addr_in_range: assert property (
        @(posedge clk) disable iff (!rst_n) (state == exec) |-> (pc < (RAM_AW + 1)'(depth))
    );

endmodule

// ==== cmd_ram.sv ====
`timescale 1ns/1ps

module cmd_ram #(
    parameter int RAM_AW = 10
) (
    input  logic                         clk,
    input  logic                         wr_en,
    input  logic [RAM_AW-1:0]            wr_addr,
    input  logic [board_pkg::word_w-1:0] wr_data,
    input  logic [RAM_AW-1:0]            rd_addr,
    output logic [board_pkg::word_w-1:0] rd_data
);

    logic [board_pkg::word_w-1:0] mem [0:2**RAM_AW-1];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read maps onto block ram
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== uart_loader.sv ====
`timescale 1ns/1ps

module uart_loader #(
    parameter int RAM_AW = 10
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [7:0]                 rx_byte,
    input  logic                       rx_valid,
    output logic                       wr_en,
    output logic [RAM_AW-1:0]          wr_addr,
    output logic [board_pkg::word_w-1:0] wr_data,
    output logic                       done,
    output logic [RAM_AW:0]            word_count
);

    localparam int depth = 2 ** RAM_AW;

    logic                         have_count;
    logic [1:0]                   byte_sel;
    logic [7:0]                   remaining;
    logic [RAM_AW-1:0]            next_addr;
    logic                         last_wr;
    logic [board_pkg::word_w-1:0] word_buf;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            have_count <= 1'b0;
            byte_sel   <= '0;
            remaining  <= '0;
            next_addr  <= '0;
            wr_en      <= 1'b0;
            wr_addr    <= '0;
            last_wr    <= 1'b0;
            done       <= 1'b0;
            word_count <= '0;
        end else begin
            wr_en   <= 1'b0;
            last_wr <= 1'b0;
            // done follows the last write by one cycle
            if (last_wr) begin
                done <= 1'b1;
            end
            if (rx_valid && !have_count) begin
                have_count <= 1'b1;
                remaining  <= rx_byte;
                // never run the engine past the end of memory
                if (int'(rx_byte) >= depth) begin
                    word_count <= (RAM_AW + 1)'(depth);
                end else begin
                    word_count <= (RAM_AW + 1)'(rx_byte);
                end
                // empty program
                if (rx_byte == 8'd0) begin
                    last_wr <= 1'b1;
                end
            end else if (rx_valid && remaining != 8'd0) begin
                byte_sel <= byte_sel + 1'b1;
                if (byte_sel == 2'd3) begin
                    wr_en     <= 1'b1;
                    wr_addr   <= next_addr;
                    next_addr <= next_addr + 1'b1;
                    remaining <= remaining - 1'b1;
                    last_wr   <= (remaining == 8'd1);
                end
            end
        end
    end

    // bytes come lsb first, so shift in from the top
    always_ff @(posedge clk) begin
        if (rx_valid && have_count) begin
            word_buf <= {rx_byte, word_buf[board_pkg::word_w-1:8]};
            if (byte_sel == 2'd3) begin
                wr_data <= {rx_byte, word_buf[board_pkg::word_w-1:8]};
            end
        end
    end

    // memory is frozen once the engine may be running
    a_no_write_after_done: assert property (
        @(posedge clk) disable iff (!rst_n) done |-> !wr_en
    );

endmodule

// ==== uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);

    localparam int cnt_w = $clog2(CLKS_PER_BIT + 1);

    typedef enum logic [1:0] {idle, start, data, stop} state_e;

    state_e           state;
    logic             rx_meta, rx_sync;
    logic [cnt_w-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift;

    // two flops against metastability, idle level is high
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= idle;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                idle: begin
                    clk_cnt <= '0;
                    if (!rx_sync) begin
                        state <= start;
                    end
                end
                // half a bit to land in the middle of the start bit
                start: begin
                    if (clk_cnt == cnt_w'(CLKS_PER_BIT / 2 - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        // glitch, not a real start bit
                        state   <= rx_sync ? idle : data;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                data: begin
                    if (clk_cnt == cnt_w'(CLKS_PER_BIT - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= stop;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                stop: begin
                    if (clk_cnt == cnt_w'(CLKS_PER_BIT - 1)) begin
                        // framing error drops the byte
                        rx_valid <= rx_sync;
                        state    <= idle;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // lsb first, sampled at mid-bit
    always_ff @(posedge clk) begin
        if (state == data && clk_cnt == cnt_w'(CLKS_PER_BIT - 1)) begin
            shift <= {rx_sync, shift[7:1]};
        end
    end

    assign rx_byte = shift;

endmodule

// ==== board_pkg.sv ====
package board_pkg;

    // command word layout
    localparam int word_w = 32;
    localparam int op_w = 4;

    // board io widths
    localparam int led_w = 16;
    localparam int seg_digits = 4;
    localparam int key_w = 4;

    // opcode lives in the top nibble, operand below it
    typedef enum logic [op_w-1:0] {
        // no effect, pc advances
        op_nop    = 4'h0,
        // led register takes operand[15:0]
        op_led    = 4'h1,
        // display value takes operand[15:0]
        op_seg    = 4'h2,
        // wait for a key press, led register takes the key index
        op_keyled = 4'h3,
        // pc takes the operand
        op_jump   = 4'h4,
        // stop and raise halted
        op_halt   = 4'h5
    } cmd_op_e;

endpackage
